// ==== design/dp_pkg.sv ====
package dp_pkg;

	// bus word width
	localparam int DATA_W = 32;

	// bus size limit and selector width
	localparam int MAX_BUS = 8;
	localparam int SEL_W = $clog2(MAX_BUS);

	// opcode width and clz result width
	localparam int OP_W = 4;
	localparam int CLZ_W = 6;

	// per-unit configuration word: sel_a | sel_b | opcode
	localparam int ALU_CONF_W = 2 * SEL_W + OP_W;
	localparam int ALU_SEL_A_MSB = ALU_CONF_W - 1;
	localparam int ALU_SEL_B_MSB = ALU_CONF_W - SEL_W - 1;
	localparam int ALU_OP_MSB = OP_W - 1;

	// unit or output port index in a config request
	localparam int CFG_IDX_W = 3;

	typedef enum logic [OP_W-1:0] {
		OP_ADD    = 4'd0,
		OP_SUB    = 4'd1,
		OP_OR     = 4'd2,
		OP_AND    = 4'd3,
		OP_XOR    = 4'd4,
		OP_SEXT8  = 4'd5,
		OP_SEXT16 = 4'd6,
		OP_SRA    = 4'd7,
		OP_SRL    = 4'd8,
		OP_CMP_S  = 4'd9,
		OP_CMP_U  = 4'd10,
		OP_MUX    = 4'd11,
		OP_CLZ    = 4'd12,
		OP_MAX    = 4'd13,
		OP_MIN    = 4'd14,
		OP_ABS    = 4'd15
	} alu_op_e;

	// what a config request writes
	typedef enum logic [1:0] {
		CFG_ALU   = 2'd0,
		CFG_OUT   = 2'd1,
		CFG_APPLY = 2'd2
	} cfg_target_e;

endpackage

// ==== design/lead_zero_count.sv ====
module lead_zero_count (
	input  logic [dp_pkg::DATA_W-1:0] data,
	output logic [dp_pkg::CLZ_W-1:0]  count
);

	import dp_pkg::*;

	// lowest to highest, so the top set bit wins
	always_comb begin
		count = CLZ_W'(DATA_W);
		for (int i = 0; i < DATA_W; i++) begin
			if (data[i]) begin
				count = CLZ_W'(DATA_W - 1 - i);
			end
		end
	end

endmodule

// ==== design/alu_unit.sv ====
module alu_unit #(
	parameter int BUS_WORDS = 6
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [BUS_WORDS*dp_pkg::DATA_W-1:0] bus_words,
	input  logic [dp_pkg::ALU_CONF_W-1:0]       alu_cfg,
	output logic [dp_pkg::DATA_W-1:0]           alu_result
);

	import dp_pkg::*;

	localparam int ADD_W = DATA_W + 1;

	logic [SEL_W-1:0]  sel [2];
	logic [DATA_W-1:0] pick [2];
	logic [DATA_W-1:0] opnd_q [2];
	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	alu_op_e           op;

	logic [ADD_W-1:0]  a_inv;
	logic [ADD_W-1:0]  b_mask;
	logic [ADD_W-1:0]  sum;
	logic              a_ext;
	logic              b_ext;
	logic              cin;

	logic [CLZ_W-1:0]  clz_count;
	logic [DATA_W-1:0] result;

	assign sel[0] = alu_cfg[ALU_SEL_A_MSB -: SEL_W];
	assign sel[1] = alu_cfg[ALU_SEL_B_MSB -: SEL_W];
	assign op = alu_op_e'(alu_cfg[ALU_OP_MSB -: OP_W]);

	// operand A and B pick and register
	for (genvar g = 0; g < 2; g++) begin : g_opnd
		always_comb begin
			pick[g] = '0;
			if (sel[g] < BUS_WORDS) begin
				pick[g] = bus_words[sel[g]*DATA_W +: DATA_W];
			end
		end

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				opnd_q[g] <= '0;
			end else begin
				opnd_q[g] <= pick[g];
			end
		end
	end

	assign op_a = opnd_q[0];
	assign op_b = opnd_q[1];

	// adder setup: invert A for B-A, sign bits for signed ops
	always_comb begin
		a_inv = '0;
		b_mask = '1;
		a_ext = 1'b0;
		b_ext = 1'b0;
		cin = 1'b0;
		case (op)
			OP_SUB, OP_CMP_U: begin
				a_inv = '1;
				cin = 1'b1;
			end
			OP_CMP_S, OP_MAX, OP_MIN: begin
				a_inv = '1;
				cin = 1'b1;
				a_ext = op_a[DATA_W-1];
				b_ext = op_b[DATA_W-1];
			end
			OP_ABS: begin
				// B is dropped, A negated when negative
				b_mask = '0;
				if (op_a[DATA_W-1]) begin
					a_inv = '1;
					cin = 1'b1;
				end
			end
			default: begin
			end
		endcase
	end

	assign sum = (b_mask & {b_ext, op_b}) + (a_inv ^ {a_ext, op_a}) + ADD_W'(cin);

	lead_zero_count u_clz (
		.data  (op_a),
		.count (clz_count)
	);

	always_comb begin
		result = sum[DATA_W-1:0];
		case (op)
			OP_OR:     result = op_a | op_b;
			OP_AND:    result = op_a & op_b;
			OP_XOR:    result = op_a ^ op_b;
			OP_SEXT8:  result = {{(DATA_W-8){op_a[7]}}, op_a[7:0]};
			OP_SEXT16: result = {{(DATA_W-16){op_a[15]}}, op_a[15:0]};
			OP_SRA:    result = {op_a[DATA_W-1], op_a[DATA_W-1:1]};
			OP_SRL:    result = {1'b0, op_a[DATA_W-1:1]};
			// borrow of B-A on top bit
			OP_CMP_S,
			OP_CMP_U:  result = {sum[ADD_W-1], {(DATA_W-1){1'b0}}};
			OP_MUX:    result = op_a[DATA_W-1] ? '0 : op_b;
			OP_CLZ:    result = DATA_W'(clz_count);
			OP_MAX:    result = sum[ADD_W-1] ? op_a : op_b;
			OP_MIN:    result = sum[ADD_W-1] ? op_b : op_a;
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_result <= '0;
		end else begin
			alu_result <= result;
		end
	end

endmodule

// ==== design/config_loader.sv ====
module config_loader #(
	parameter int N_ALU = 4,
	parameter int N_OUT = 2
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cfg_req,
	input  dp_pkg::cfg_target_e                 cfg_target,
	input  logic [dp_pkg::CFG_IDX_W-1:0]        cfg_idx,
	input  logic [dp_pkg::ALU_CONF_W-1:0]       cfg_data,
	output logic                                cfg_ack,
	output logic [N_ALU*dp_pkg::ALU_CONF_W-1:0] alu_cfg_all,
	output logic [N_OUT*dp_pkg::SEL_W-1:0]      out_sel
);

	import dp_pkg::*;

	typedef enum logic {
		IDLE,
		ACKED
	} ld_state_e;

	ld_state_e                    state;
	logic                         accept;
	logic [N_ALU*ALU_CONF_W-1:0]  alu_shadow;
	logic [N_OUT*SEL_W-1:0]       out_shadow;

	assign accept = (state == IDLE) && cfg_req;
	assign cfg_ack = (state == ACKED);

	// four-phase handshake
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: if (cfg_req) state <= ACKED;
				ACKED: if (!cfg_req) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// shadow writes; apply copies everything at once
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_shadow <= '0;
			out_shadow <= '0;
			alu_cfg_all <= '0;
			out_sel <= '0;
		end else if (accept) begin
			case (cfg_target)
				CFG_ALU: begin
					for (int i = 0; i < N_ALU; i++) begin
						if (cfg_idx == CFG_IDX_W'(i)) begin
							alu_shadow[i*ALU_CONF_W +: ALU_CONF_W] <= cfg_data;
						end
					end
				end
				CFG_OUT: begin
					for (int i = 0; i < N_OUT; i++) begin
						if (cfg_idx == CFG_IDX_W'(i)) begin
							out_shadow[i*SEL_W +: SEL_W] <= cfg_data[SEL_W-1:0];
						end
					end
				end
				CFG_APPLY: begin
					alu_cfg_all <= alu_shadow;
					out_sel <= out_shadow;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== design/output_select.sv ====
module output_select #(
	parameter int BUS_WORDS = 6,
	parameter int N_OUT = 2
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic [BUS_WORDS*dp_pkg::DATA_W-1:0] bus_words,
	input  logic [N_OUT*dp_pkg::SEL_W-1:0]      out_sel,
	output logic [N_OUT*dp_pkg::DATA_W-1:0]     data_out
);

	import dp_pkg::*;

	for (genvar p = 0; p < N_OUT; p++) begin : g_port
		logic [SEL_W-1:0]  sel;
		logic [DATA_W-1:0] pick;

		assign sel = out_sel[p*SEL_W +: SEL_W];

		// words past the bus read as zero
		always_comb begin
			pick = '0;
			if (sel < BUS_WORDS) begin
				pick = bus_words[sel*DATA_W +: DATA_W];
			end
		end

		always_ff @(posedge clk or posedge rst) begin
			if (rst) begin
				data_out[p*DATA_W +: DATA_W] <= '0;
			end else begin
				data_out[p*DATA_W +: DATA_W] <= pick;
			end
		end
	end

endmodule

// ==== design/alu_array.sv ====
module alu_array #(
	parameter int N_ALU = 4,
	parameter int N_EXT = 2,
	parameter int N_OUT = 2
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [N_EXT*dp_pkg::DATA_W-1:0] ext_in,
	output logic [N_OUT*dp_pkg::DATA_W-1:0] data_out,
	input  logic                            cfg_req,
	input  dp_pkg::cfg_target_e             cfg_target,
	input  logic [dp_pkg::CFG_IDX_W-1:0]    cfg_idx,
	input  logic [dp_pkg::ALU_CONF_W-1:0]   cfg_data,
	output logic                            cfg_ack
);

	import dp_pkg::*;

	// external words first, then one result word per unit
	localparam int BUS_WORDS = N_EXT + N_ALU;

	logic [BUS_WORDS*DATA_W-1:0] bus_words;
	logic [N_ALU*ALU_CONF_W-1:0] alu_cfg_all;
	logic [N_OUT*SEL_W-1:0]      out_sel;

	assign bus_words[N_EXT*DATA_W-1:0] = ext_in;

	config_loader #(
		.N_ALU (N_ALU),
		.N_OUT (N_OUT)
	) u_loader (
		.clk         (clk),
		.rst         (rst),
		.cfg_req     (cfg_req),
		.cfg_target  (cfg_target),
		.cfg_idx     (cfg_idx),
		.cfg_data    (cfg_data),
		.cfg_ack     (cfg_ack),
		.alu_cfg_all (alu_cfg_all),
		.out_sel     (out_sel)
	);

	for (genvar g = 0; g < N_ALU; g++) begin : g_alu
		alu_unit #(
			.BUS_WORDS (BUS_WORDS)
		) u_alu (
			.clk        (clk),
			.rst        (rst),
			.bus_words  (bus_words),
			.alu_cfg    (alu_cfg_all[g*ALU_CONF_W +: ALU_CONF_W]),
			.alu_result (bus_words[(N_EXT+g)*DATA_W +: DATA_W])
		);
	end

	output_select #(
		.BUS_WORDS (BUS_WORDS),
		.N_OUT     (N_OUT)
	) u_out (
		.clk       (clk),
		.rst       (rst),
		.bus_words (bus_words),
		.out_sel   (out_sel),
		.data_out  (data_out)
	);

endmodule

// ==== verification/alu_array_tb.sv ====
module alu_array_tb;

	import dp_pkg::*;

	localparam int N_ALU = 4;
	localparam int N_EXT = 2;
	localparam int N_OUT = 2;
	localparam int SETTLE = 2 * N_ALU + 2;
	localparam int ACK_WAIT = 4;
	localparam int GOLD_DEPTH = 512;

	// entry kinds in the golden file
	localparam logic [DATA_W-1:0] KIND_FIRST = 'ha;
	localparam logic [DATA_W-1:0] KIND_HELD = 'hb;
	localparam logic [DATA_W-1:0] KIND_CFG = 'hc;
	localparam logic [DATA_W-1:0] KIND_DRIVE = 'hd;
	localparam logic [DATA_W-1:0] KIND_SETTLED = 'he;

	logic                    clk;
	logic                    rst;
	logic [N_EXT*DATA_W-1:0] ext_in;
	logic [N_OUT*DATA_W-1:0] data_out;
	logic                    cfg_req;
	cfg_target_e             cfg_target;
	logic [CFG_IDX_W-1:0]    cfg_idx;
	logic [ALU_CONF_W-1:0]   cfg_data;
	logic                    cfg_ack;

	logic [DATA_W-1:0] gold [GOLD_DEPTH];
	int data_errors = 0;
	int hs_errors = 0;
	int file_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	alu_array #(
		.N_ALU (N_ALU),
		.N_EXT (N_EXT),
		.N_OUT (N_OUT)
	) u_dut (
		.clk        (clk),
		.rst        (rst),
		.ext_in     (ext_in),
		.data_out   (data_out),
		.cfg_req    (cfg_req),
		.cfg_target (cfg_target),
		.cfg_idx    (cfg_idx),
		.cfg_data   (cfg_data),
		.cfg_ack    (cfg_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// words an entry takes, zero ends the list
	function automatic int entry_words(input logic [DATA_W-1:0] kind);
		case (kind)
			KIND_CFG: return 4;
			KIND_DRIVE, KIND_FIRST, KIND_HELD, KIND_SETTLED: return 3;
			default: return 0;
		endcase
	endfunction

	task automatic check_outputs(input logic [DATA_W-1:0] exp0, input logic [DATA_W-1:0] exp1);
		logic [DATA_W-1:0] exp_word [N_OUT];
		logic [DATA_W-1:0] got;
		exp_word[0] = exp0;
		exp_word[1] = exp1;
		for (int p = 0; p < N_OUT; p++) begin
			got = data_out[p*DATA_W +: DATA_W];
			assert (got == exp_word[p]) else begin
				data_errors++;
				$display("[ERROR] %0t data_out[%0d] expected %h got %h",
					$time, p, exp_word[p], got);
			end
		end
	endtask

	// one four-phase transfer
	task automatic write_config(input logic [1:0] target, input logic [CFG_IDX_W-1:0] idx,
		input logic [ALU_CONF_W-1:0] data);
		int waited;
		@(posedge clk);
		cfg_target <= cfg_target_e'(target);
		cfg_idx <= idx;
		cfg_data <= data;
		cfg_req <= 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			@(negedge clk);
			waited++;
		end while (!cfg_ack && waited < ACK_WAIT);
		assert (cfg_ack) else begin
			hs_errors++;
			$display("%0t: cfg_ack did not rise within %0d cycles of cfg_req", $time, ACK_WAIT);
		end
		@(posedge clk);
		cfg_req <= 1'b0;
		waited = 0;
		do begin
			@(posedge clk);
			@(negedge clk);
			waited++;
		end while (cfg_ack && waited < ACK_WAIT);
		assert (!cfg_ack) else begin
			hs_errors++;
			$display("%0t: cfg_ack still high %0d cycles after cfg_req fell", $time, ACK_WAIT);
		end
	endtask

	initial begin
		while (cycle_limit == 0 || cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int pos;
		int n_rec;
		logic [DATA_W-1:0] kind;
		rst = 1'b1;
		ext_in = '0;
		cfg_req = 1'b0;
		cfg_target = CFG_ALU;
		cfg_idx = '0;
		cfg_data = '0;
		for (int i = 0; i < GOLD_DEPTH; i++) begin
			gold[i] = '0;
		end
		$readmemh("verification/alu_array_golden.txt", gold);

		// one record per settled check
		pos = 0;
		n_rec = 0;
		while (pos < GOLD_DEPTH && entry_words(gold[pos]) > 0) begin
			if (gold[pos] == KIND_SETTLED) begin
				n_rec++;
			end
			pos += entry_words(gold[pos]);
		end
		if (n_rec == 0) begin
			file_errors++;
			$display("golden file is missing or holds no records");
		end
		cycle_limit = n_rec * 40;

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (data_out == '0) else begin
			data_errors++;
			$display("[ERROR] %0t data_out expected %h got %h", $time, '0, data_out);
		end
		assert (cfg_ack == 1'b0) else begin
			data_errors++;
			$display("[ERROR] %0t cfg_ack expected 0 got %b", $time, cfg_ack);
		end

		pos = 0;
		while (pos < GOLD_DEPTH && entry_words(gold[pos]) > 0) begin
			kind = gold[pos];
			case (kind)
				KIND_CFG: begin
					write_config(gold[pos+1][1:0], CFG_IDX_W'(gold[pos+2]),
						ALU_CONF_W'(gold[pos+3]));
				end
				KIND_DRIVE: begin
					@(posedge clk);
					ext_in <= {gold[pos+2], gold[pos+1]};
				end
				KIND_FIRST: begin
					@(posedge clk);
					@(negedge clk);
					check_outputs(gold[pos+1], gold[pos+2]);
				end
				KIND_SETTLED: begin
					repeat (SETTLE) @(posedge clk);
					@(negedge clk);
					check_outputs(gold[pos+1], gold[pos+2]);
				end
				KIND_HELD: begin
					@(negedge clk);
					check_outputs(gold[pos+1], gold[pos+2]);
				end
				default: begin
				end
			endcase
			pos += entry_words(kind);
		end

		$display("errors: %0d data, %0d handshake, %0d golden file",
			data_errors, hs_errors, file_errors);
		if (data_errors + hs_errors + file_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verification/alu_array_golden.txt ====
// c <target> <idx> <data>: config write; d <ext0> <ext1>: drive ext_in
// a / e <out0> <out1>: expect data_out one cycle after d / after settling
// b <out0> <out1>: expect data_out unchanged before the apply
d 12345678 9abcdef0 a 12345678 12345678 e 12345678 12345678
c 0 0 010 c 0 1 011 c 1 0 2 c 1 1 3 b 12345678 12345678 c 2 0 0
d 7fffffff 00000001 e 80000000 80000002
c 0 0 012 c 0 1 013 b 80000000 80000002 c 2 0 0
d f0f0f0f0 ff00ff00 e fff0fff0 f000f000
c 0 0 014 c 0 1 005 b fff0fff0 f000f000 c 2 0 0
d 00000080 ffffffff e ffffff7f ffffff80
c 0 0 006 c 0 1 087 b ffffff7f ffffff80 c 2 0 0
d 00008001 80000001 e ffff8001 c0000000
c 0 0 088 c 0 1 019 b ffff8001 c0000000 c 2 0 0
d 00000001 80000000 e 40000000 80000000
c 0 0 01a c 0 1 009 b 40000000 80000000 c 2 0 0
d 80000000 00000001 e 80000000 00000000
c 0 0 01b c 0 1 00c b 80000000 00000000 c 2 0 0
d 00000000 12345678 e 12345678 00000020
c 0 1 08c b 12345678 00000020 c 2 0 0
d 80000000 00010000 e 00000000 0000000f
c 0 0 01d c 0 1 01e b 00000000 0000000f c 2 0 0
d ffffffff 00000001 e 00000001 ffffffff
c 0 0 00e c 0 1 00f b 00000001 ffffffff c 2 0 0
d 80000001 00000000 e 80000001 7fffffff
c 0 0 09d b 80000001 7fffffff c 2 0 0
d 00000005 80000000 e 80000000 00000005
c 0 0 010 c 0 1 114 c 0 2 1a0 c 1 0 4 b 80000000 00000005 c 2 0 0
d 00000010 00000003 e 00000023 00000010
c 0 5 00f c 1 1 6 c 1 3 2 b 00000023 00000010 c 2 0 0
d 00000100 00000020 e 00000220 00000000
c 0 0 000 c 1 0 2 c 1 1 1 b 00000220 00000000 c 2 0 0
d 00000000 00000009 e 00000000 00000009
c 0 0 100 b 00000000 00000009 c 2 0 0
d 00000005 00000009 e 00000014 00000009

// ==== alu_array.f ====
design/dp_pkg.sv
design/lead_zero_count.sv
design/alu_unit.sv
design/config_loader.sv
design/output_select.sv
design/alu_array.sv
verification/alu_array_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the alu_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=alu_array_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module alu_array_tb \
	-f alu_array.f \
	--Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./"$BUILD_DIR"/"$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
	exit 0
else
	exit 1
fi
